//--- vlog.f
hdl/swi_pkg.sv
hdl/swi_alu.sv
hdl/swi_addr_unit.sv
hdl/swi_control.sv
hdl/swi_cpu.sv
testbench/swi_cpu_asserts.sv
testbench/swi_checker.sv
testbench/tb_swi_cpu.sv

//--- run.sh
#!/bin/sh
# Build and run the swi_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_swi_cpu -o sim_swi
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_swi)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1

//--- testbench/tb_swi_cpu.sv
// ******************************
// Testbench top: clock, reset, random programs,
// Wishbone memory, test loop and watchdog
// ******************************
`timescale 1ns/1ps

module tb_swi_cpu;

  import swi_pkg::*;

  localparam logic [31:0] SEED        = 32'h8dda_7c08;
  localparam int          PROG_LEN    = 24;    // Words per program, last one stops
  localparam int          MEM_WORDS   = 2048;  // 8 KB, stack sits above the code
  localparam int          NUM_TESTS   = 8;
  localparam int          CYCLE_LIMIT = NUM_TESTS * PROG_LEN * 40;
  localparam int          N_OPS       = 34;

  // PUTC twice so output shows up often
  localparam op_e OPS [N_OPS] = '{ADD, ADDI, SUB, SUBI, AND, ANDI, OR, ORI, XOR, XORI,
    MUL, MULI, SHL, SHR, SRU, EQ, NE, LT, LTU, LI, LBI, LBA, BZ, BNZ, BE, BNE, JMP,
    LL, SL, PSHA, POPA, ENT, PUTC, PUTC};

  logic        i_clk   = 1'b0;
  logic        i_rst_n = 1'b0;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp  = '0;
  putc_t       putc;
  logic        halted;
  logic [31:0] image [MEM_WORDS];  // Program loaded into mem during reset
  logic [31:0] mem   [MEM_WORDS];
  logic [31:0] prog_seed;
  logic [31:0] wait_seed = SEED;
  logic        zero_wait = 1'b1;   // First test runs without wait states
  logic        busy      = 1'b0;
  logic [1:0]  waits     = 2'd0;

  always #5 i_clk = ~i_clk;

  swi_cpu UUT (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .o_wb_req (wb_req),
    .i_wb_rsp (wb_rsp),
    .o_putc   (putc),
    .o_halted (halted)
  );

  swi_checker #(.P_MEM_WORDS(MEM_WORDS), .P_PROG_LEN(PROG_LEN)) chk (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_putc   (putc),
    .i_halted (halted),
    .i_req    (wb_req)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int word_idx(input logic [31:0] adr);
    return int'((adr >> 2) % MEM_WORDS);
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    logic [15:0] h;
    h = 16'(i);
    return {~h, h ^ 16'hC3A5};  // Unique per address
  endfunction

  // One random instruction, branches only go forward
  function automatic logic [31:0] make_insn(input int i, input int t);
    logic [23:0] r;
    logic [23:0] imm;
    op_e         op;
    int          k;
    prog_seed = lcg(prog_seed);
    r   = prog_seed[31:8];  // Upper bits, low LCG bits repeat
    op  = OPS[int'(r[23:16] % 8'd34)];
    imm = {{16{r[7]}}, r[7:0]};
    if (i == PROG_LEN - 1) return (t % 2 == 1) ? 32'h0000_00FF : 32'h0;  // Illegal or HALT
    case (op)
      ENT: begin
        k   = int'(r[2:0]) % 5 - 2;
        imm = 24'(k * 8);
      end
      LL, SL: begin
        k   = int'(r[3:0]) % 8 - 4;
        imm = 24'(k * 4);
      end
      BZ, BNZ, BE, BNE, JMP: begin
        k = int'(r[1:0]) % 3;
        if (i + 1 + k > PROG_LEN - 1) k = 0;
        imm = 24'(k * 4);
      end
      default: ;
    endcase
    return {imm, op};
  endfunction

  // Wishbone slave with 0 to 3 random wait states
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      wb_rsp.ack <= 1'b0;
      busy       <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] <= image[i];
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;  // One ack per request
    end else if (!busy && wb_req.cyc && wb_req.stb) begin
      busy      <= 1'b1;
      wait_seed <= lcg(wait_seed);
      waits     <= zero_wait ? 2'd0 : wait_seed[31:30];
    end else if (busy) begin
      if (waits == 2'd0) begin
        busy         <= 1'b0;
        wb_rsp.ack   <= 1'b1;
        wb_rsp.dat_r <= mem[word_idx(wb_req.adr)];
        if (wb_req.we) mem[word_idx(wb_req.adr)] <= wb_req.dat_w;
      end else begin
        waits <= waits - 2'd1;
      end
    end
  end

  initial begin
    prog_seed = SEED;
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge i_clk);
      i_rst_n   <= 1'b0;
      zero_wait <= (t == 0);
      for (int i = 0; i < MEM_WORDS; i++) begin
        image[i] = (i < PROG_LEN) ? make_insn(i, t) : fill_word(i);
        chk.load_word(i, image[i]);
      end
      chk.run_model();
      repeat (2) @(posedge i_clk);
      i_rst_n <= 1'b1;
      wait (halted);
      repeat (4) @(posedge i_clk);  // Let stray requests show up
      for (int i = 0; i < MEM_WORDS; i++) chk.check_word(i, mem[i]);
      chk.end_test(t);
    end
    $display("tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
      NUM_TESTS, chk.tests_failed, chk.err_total, UUT.u_asserts.fail_count);
    if (chk.err_total == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(CYCLE_LIMIT * 10);
    $display("timeout: DUT did not finish within %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- testbench/swi_checker.sv
// ******************************
// Instruction-set model and output comparison
// ******************************
`timescale 1ns/1ps

module swi_checker #(
  parameter int P_MEM_WORDS = 2048,
  parameter int P_PROG_LEN  = 24
) (
  input logic             i_clk,
  input logic             i_rst_n,
  input swi_pkg::putc_t   i_putc,
  input logic             i_halted,
  input swi_pkg::wb_req_t i_req
);

  import swi_pkg::*;

  logic [31:0] model_mem [P_MEM_WORDS];
  logic [7:0]  exp_q [$];  // Characters the model printed
  int          seen      = 0;  // Bumped only by the monitor
  int          mon_errs  = 0;
  int          seen_base;
  int          mon_base;
  int          err_test;
  int          err_total    = 0;
  int          tests_failed = 0;

  function automatic int word_idx(input logic [31:0] adr);
    return int'((adr >> 2) % P_MEM_WORDS);
  endfunction

  task automatic load_word(input int i, input logic [31:0] w);
    model_mem[i] = w;
  endtask

  // Runs the program from reset values PC 0, SP 0x1000
  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] sp;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ir;
    logic [31:0] imm;
    int          steps;
    logic        done;
    pc       = 32'h0;
    sp       = 32'h0000_1000;
    a        = '0;
    b        = '0;
    done     = 1'b0;
    steps    = 0;
    err_test = 0;
    exp_q.delete();
    seen_base = seen;
    mon_base  = mon_errs;
    while (!done && steps < 4 * P_PROG_LEN) begin
      ir  = model_mem[word_idx(pc)];
      pc  = pc + 32'd4;
      imm = {{8{ir[31]}}, ir[31:8]};
      steps++;
      case (ir[7:0])
        ADD:  a = a + b;
        ADDI: a = a + imm;
        SUB:  a = a - b;
        SUBI: a = a - imm;
        AND:  a = a & b;
        ANDI: a = a & imm;
        OR:   a = a | b;
        ORI:  a = a | imm;
        XOR:  a = a ^ b;
        XORI: a = a ^ imm;
        MUL:  a = a * b;
        MULI: a = a * imm;
        SHL:  a = a << b;
        SHR:  a = $signed(a) >>> b;
        SRU:  a = a >> b;
        EQ:   a = {31'b0, a == b};
        NE:   a = {31'b0, a != b};
        LT:   a = {31'b0, $signed(a) < $signed(b)};
        LTU:  a = {31'b0, a < b};
        LI:   a = imm;
        LBI:  b = imm;
        LBA:  b = a;
        BZ:   if (a == 0) pc = pc + imm;
        BNZ:  if (a != 0) pc = pc + imm;
        BE:   if (a == b) pc = pc + imm;
        BNE:  if (a != b) pc = pc + imm;
        JMP:  pc = pc + imm;
        LL:   a = model_mem[word_idx(sp + imm)];
        SL:   model_mem[word_idx(sp + imm)] = a;
        PSHA: begin
          sp = sp - 32'd8;
          model_mem[word_idx(sp)] = a;
        end
        POPA: begin
          a  = model_mem[word_idx(sp)];
          sp = sp + 32'd8;
        end
        ENT:  sp = sp + imm;
        PUTC: exp_q.push_back(a[7:0]);
        default: done = 1'b1;  // HALT and illegal codes
      endcase
    end
    if (!done) begin
      $display("model did not reach a halt");
      err_test++;
    end
  endtask

  // Live output watch
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (i_putc.valid) begin
        if (seen - seen_base >= exp_q.size()) begin
          $display("DUT printed more characters than expected");
          mon_errs <= mon_errs + 1;
        end else if (i_putc.data !== exp_q[seen - seen_base]) begin
          $display("error: o_putc.data got %h expected %h", i_putc.data,
            exp_q[seen - seen_base]);
          mon_errs <= mon_errs + 1;
        end
        seen <= seen + 1;
      end
      if (i_halted && i_req.stb) begin
        $display("DUT issued a bus request after halting");
        mon_errs <= mon_errs + 1;
      end
    end
  end

  task automatic check_word(input int i, input logic [31:0] dut_w);
    if (dut_w !== model_mem[i]) begin
      $display("error: mem[%h] got %h expected %h", 32'(i * 4), dut_w, model_mem[i]);
      err_test++;
    end
  endtask

  task automatic end_test(input int t);
    if (seen - seen_base != exp_q.size()) begin
      $display("DUT printed %0d of %0d expected characters", seen - seen_base, exp_q.size());
      err_test++;
    end
    err_test = err_test + (mon_errs - mon_base);
    err_total = err_total + err_test;
    if (err_test != 0) tests_failed++;
    $display("test %0d: %0d chars, %0d errors, %s", t, exp_q.size(), err_test,
      (err_test == 0) ? "ok" : "failed");
  endtask

endmodule

//--- testbench/swi_cpu_asserts.sv
// ******************************
// Bus and halt assertions, bound to swi_cpu
// ******************************
`timescale 1ns/1ps

module swi_cpu_asserts (
  input logic             i_clk,
  input logic             i_rst_n,
  input swi_pkg::wb_req_t i_req,
  input logic             i_ack,
  input logic             i_halted
);

  int fail_count = 0;

  a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_req.stb |-> i_req.cyc)
    else begin
      $error("stb high while cyc low");
      fail_count++;
    end

  // Request held until the slave acks
  a_req_steady: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_req.stb && !i_ack) |=> $stable(i_req))
    else begin
      $error("request changed before ack");
      fail_count++;
    end

  a_halt_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halted |=> i_halted)
    else begin
      $error("o_halted fell");
      fail_count++;
    end

endmodule

bind swi_cpu swi_cpu_asserts u_asserts (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_req    (o_wb_req),
  .i_ack    (i_wb_rsp.ack),
  .i_halted (o_halted)
);

//--- hdl/swi_cpu.sv
// ******************************
// Swieros CPU top, control with ALU
// and address unit
// ******************************
`timescale 1ns/1ps

module swi_cpu #(
  parameter logic [swi_pkg::XLEN-1:0] P_ENTRY_PC  = '0,           // Reset PC
  parameter logic [swi_pkg::XLEN-1:0] P_STACK_TOP = 32'h0000_1000  // Reset SP
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  output swi_pkg::wb_req_t  o_wb_req,
  input  swi_pkg::wb_rsp_t  i_wb_rsp,
  output swi_pkg::putc_t    o_putc,
  output logic              o_halted
);

  import swi_pkg::*;

  alu_in_t         alu_in;
  logic [XLEN-1:0] alu_result;
  addr_in_t        addr_in;
  logic [XLEN-1:0] ea;
  logic            br_taken;
  logic [XLEN-1:0] br_target;

  swi_control #(
    .P_ENTRY_PC  (P_ENTRY_PC),
    .P_STACK_TOP (P_STACK_TOP)
  ) u_control (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_wb_req     (o_wb_req),
    .i_wb_rsp     (i_wb_rsp),
    .o_alu        (alu_in),
    .i_alu_result (alu_result),
    .o_addr       (addr_in),
    .i_ea         (ea),
    .i_br_taken   (br_taken),
    .i_br_target  (br_target),
    .o_putc       (o_putc),
    .o_halted     (o_halted)
  );

  // Both units settle within the EXEC cycle
  swi_alu u_alu (
    .i_alu    (alu_in),
    .o_result (alu_result)
  );

  swi_addr_unit u_addr (
    .i_addr      (addr_in),
    .o_ea        (ea),
    .o_br_taken  (br_taken),
    .o_br_target (br_target)
  );

endmodule

//--- hdl/swi_control.sv
// ******************************
// Registers, FSM, Wishbone master, decode
// and write back selection
// ******************************
`timescale 1ns/1ps

module swi_control #(
  parameter logic [swi_pkg::XLEN-1:0] P_ENTRY_PC  = '0,
  parameter logic [swi_pkg::XLEN-1:0] P_STACK_TOP = 32'h0000_1000
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  output swi_pkg::wb_req_t          o_wb_req,
  input  swi_pkg::wb_rsp_t          i_wb_rsp,
  output swi_pkg::alu_in_t          o_alu,
  input  logic [swi_pkg::XLEN-1:0]  i_alu_result,
  output swi_pkg::addr_in_t         o_addr,
  input  logic [swi_pkg::XLEN-1:0]  i_ea,
  input  logic                      i_br_taken,
  input  logic [swi_pkg::XLEN-1:0]  i_br_target,
  output swi_pkg::putc_t            o_putc,
  output logic                      o_halted
);

  import swi_pkg::*;

  localparam logic [XLEN-1:0] SLOT = XLEN'(8);  // Stack slot size
  localparam logic [XLEN-1:0] INSN = XLEN'(4);  // Instruction size

  state_e          state;
  logic [XLEN-1:0] reg_a;
  logic [XLEN-1:0] reg_b;
  logic [XLEN-1:0] sp;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] ir;   // Loaded on fetch ack only

  op_e             op;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] sp_next;

  // Decode flags
  logic wr_a;
  logic wr_b;
  logic wr_sp;
  logic use_imm;
  logic is_mem;
  logic is_store;
  logic is_halt;

  assign op  = op_e'(ir[7:0]);
  assign imm = {{(XLEN-IMM_W){ir[XLEN-1]}}, ir[XLEN-1:XLEN-IMM_W]};  // Sign extend

  assign pc_next = i_br_taken ? i_br_target : pc;

  // Fetch request to a given address
  function automatic wb_req_t bus_rd(input logic [XLEN-1:0] adr);
    wb_req_t req;
    req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: '0};
    return req;
  endfunction

  always_comb begin
    wr_a     = 1'b0;
    wr_b     = 1'b0;
    wr_sp    = 1'b0;
    use_imm  = 1'b0;
    is_mem   = 1'b0;
    is_store = 1'b0;
    is_halt  = 1'b0;
    sp_next  = i_ea;  // ENT and PSHA take the address unit sum
    case (op)
      ADD, SUB, AND, OR, XOR, MUL, SHL, SHR, SRU: wr_a = 1'b1;
      EQ, NE, LT, LTU:                            wr_a = 1'b1;
      ADDI, SUBI, ANDI, ORI, XORI, MULI, LI: begin
        wr_a    = 1'b1;
        use_imm = 1'b1;
      end
      LBI: begin
        wr_b    = 1'b1;
        use_imm = 1'b1;
      end
      LBA:                    wr_b = 1'b1;
      BZ, BNZ, BE, BNE, JMP: ;  // PC only, through pc_next
      PUTC:                  ;  // Strobe below
      ENT:                    wr_sp = 1'b1;
      PSHA: begin
        wr_sp    = 1'b1;
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      POPA: begin
        wr_sp   = 1'b1;
        sp_next = sp + SLOT;
        is_mem  = 1'b1;
      end
      LL:                     is_mem = 1'b1;
      SL: begin
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      HALT:                   is_halt = 1'b1;
      default:                is_halt = 1'b1;  // Illegal opcode stops too
    endcase
  end

  // Operand: read data in MEM, else immediate or B
  always_comb begin
    o_alu.op = op;
    o_alu.a  = reg_a;
    if (state == S_MEM) begin
      o_alu.operand = i_wb_rsp.dat_r;
    end else if (use_imm) begin
      o_alu.operand = imm;
    end else begin
      o_alu.operand = reg_b;
    end
  end

  assign o_addr = '{op: op, a: reg_a, b: reg_b, sp: sp, pc: pc, imm: imm};

  assign o_putc.valid = (state == S_EXEC) && (op == PUTC);  // One cycle
  assign o_putc.data  = reg_a[7:0];
  assign o_halted     = (state == S_HALT);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state        <= S_FETCH;
      pc           <= P_ENTRY_PC;
      sp           <= P_STACK_TOP;
      reg_a        <= '0;
      reg_b        <= '0;
      o_wb_req.cyc <= 1'b0;
      o_wb_req.stb <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          if (!o_wb_req.cyc) begin
            o_wb_req <= bus_rd(pc);  // Bus idle, start the fetch
          end else if (i_wb_rsp.ack) begin
            o_wb_req.cyc <= 1'b0;
            o_wb_req.stb <= 1'b0;
            ir           <= i_wb_rsp.dat_r;
            pc           <= pc + INSN;
            state        <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (wr_a) reg_a <= i_alu_result;
          if (wr_b) reg_b <= i_alu_result;
          if (wr_sp) sp <= sp_next;
          pc <= pc_next;
          if (is_halt) begin
            state <= S_HALT;  // No more requests
          end else if (is_mem) begin
            // Address comes from the old SP
            o_wb_req <= '{cyc: 1'b1, stb: 1'b1, we: is_store, adr: i_ea, dat_w: reg_a};
            state    <= S_MEM;
          end else begin
            o_wb_req <= bus_rd(pc_next);  // Next fetch straight away
            state    <= S_FETCH;
          end
        end
        S_MEM: begin
          if (i_wb_rsp.ack) begin
            o_wb_req.cyc <= 1'b0;
            o_wb_req.stb <= 1'b0;
            if (!is_store) reg_a <= i_alu_result;  // LL, POPA
            state <= S_FETCH;
          end
        end
        default: state <= S_HALT;
      endcase
    end
  end

endmodule

//--- hdl/swi_addr_unit.sv
// ******************************
// Stack effective address, branch condition
// and branch target
// ******************************
`timescale 1ns/1ps

module swi_addr_unit (
  input  swi_pkg::addr_in_t         i_addr,
  output logic [swi_pkg::XLEN-1:0]  o_ea,
  output logic                      o_br_taken,
  output logic [swi_pkg::XLEN-1:0]  o_br_target
);

  import swi_pkg::*;

  localparam logic [XLEN-1:0] SLOT = XLEN'(8);  // One stack slot in bytes

  logic [XLEN-1:0] sp_imm;
  logic            a_zero;

  assign sp_imm = i_addr.sp + i_addr.imm;
  assign a_zero = (i_addr.a == '0);

  // Effective address from the old SP
  // ENT also takes SP + imm as its new SP
  always_comb begin
    case (i_addr.op)
      PSHA:    o_ea = i_addr.sp - SLOT;  // Predecrement
      POPA:    o_ea = i_addr.sp;         // SP bumps after the read
      default: o_ea = sp_imm;            // LL, SL, ENT
    endcase
  end

  // PC has moved past the branch already
  assign o_br_target = i_addr.pc + i_addr.imm;

  always_comb begin
    case (i_addr.op)
      BZ:      o_br_taken = a_zero;
      BNZ:     o_br_taken = !a_zero;
      BE:      o_br_taken = (i_addr.a == i_addr.b);
      BNE:     o_br_taken = (i_addr.a != i_addr.b);
      JMP:     o_br_taken = 1'b1;  // Always
      default: o_br_taken = 1'b0;  // Not a branch
    endcase
  end

endmodule

//--- hdl/swi_alu.sv
// ******************************
// Combinational ALU: arithmetic, logic, shifts,
// compares and load/move values
// ******************************
`timescale 1ns/1ps

module swi_alu (
  input  swi_pkg::alu_in_t          i_alu,
  output logic [swi_pkg::XLEN-1:0]  o_result
);

  import swi_pkg::*;

  logic [XLEN-1:0]        opa;
  logic [XLEN-1:0]        opb;
  logic signed [XLEN-1:0] opa_s;
  logic signed [XLEN-1:0] opb_s;
  logic                   cmp;

  assign opa   = i_alu.a;
  assign opb   = i_alu.operand;
  assign opa_s = i_alu.a;        // Signed views for SHR and LT
  assign opb_s = i_alu.operand;

  // Compare flag, only one compare opcode is live at a time
  always_comb begin
    case (i_alu.op)
      EQ:      cmp = (opa == opb);
      NE:      cmp = (opa != opb);
      LT:      cmp = (opa_s < opb_s);
      LTU:     cmp = (opa < opb);
      default: cmp = 1'b0;
    endcase
  end

  always_comb begin
    case (i_alu.op)
      ADD, ADDI: o_result = opa + opb;
      SUB, SUBI: o_result = opa - opb;
      AND, ANDI: o_result = opa & opb;
      OR, ORI:   o_result = opa | opb;
      XOR, XORI: o_result = opa ^ opb;
      MUL, MULI: o_result = opa * opb;  // Low word only
      // Full shift amount, so 32 and above flush the word
      SHL:       o_result = opa << opb;
      SHR:       o_result = opa_s >>> opb;  // Sign fill
      SRU:       o_result = opa >> opb;     // Zero fill
      EQ, NE, LT, LTU: begin
        o_result = {{(XLEN-1){1'b0}}, cmp};  // 0 or 1 in bit 0
      end
      LBA:       o_result = opa;  // B takes A
      // Immediate loads and memory reads pass the operand
      LI, LBI:   o_result = opb;
      LL, POPA:  o_result = opb;  // Read data from the bus
      default:   o_result = '0;
    endcase
  end

endmodule

//--- hdl/swi_pkg.sv
// ******************************
// Shared widths, opcode and state enums
// Wishbone, operand and character output structs
// ******************************

package swi_pkg;

  localparam int XLEN  = 32;  // Data and address width
  localparam int IMM_W = 24;  // Immediate field in IR[31:8]

  // Opcode numbering follows the Swieros table, codes not listed are illegal
  typedef enum logic [7:0] {
    HALT = 8'h00,
    ENT  = 8'h01,  // SP += imm
    JMP  = 8'h03,
    LL   = 8'h0E,  // A = mem[SP + imm]
    LI   = 8'h23,
    LBI  = 8'h3B,
    LBA  = 8'h3E,  // B = A
    SL   = 8'h40,  // mem[SP + imm] = A
    ADD  = 8'h53,
    ADDI = 8'h54,
    SUB  = 8'h56,
    SUBI = 8'h57,
    MUL  = 8'h59,
    MULI = 8'h5A,
    AND  = 8'h68,
    ANDI = 8'h69,
    OR   = 8'h6B,
    ORI  = 8'h6C,
    XOR  = 8'h6E,
    XORI = 8'h6F,
    SHL  = 8'h71,
    SHR  = 8'h74,  // Arithmetic
    SRU  = 8'h77,  // Logical
    EQ   = 8'h7A,
    NE   = 8'h7C,
    LT   = 8'h7E,  // Signed
    LTU  = 8'h7F,
    BZ   = 8'h84,
    BNZ  = 8'h86,
    BE   = 8'h88,
    BNE  = 8'h8A,
    PUTC = 8'h9A,  // Sits in the old BOUT slot
    PSHA = 8'h9D,
    POPA = 8'hA3
  } op_e;

  // Fetch runs a bus read, EXEC decodes and retires or starts a data
  // access, MEM waits on that access, HALT is never left
  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_MEM   = 2'd2,
    S_HALT  = 2'd3
  } state_e;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;    // Byte address, word aligned
    logic [XLEN-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat_r;  // Valid in the ack cycle
  } wb_rsp_t;

  typedef struct packed {
    op_e             op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] operand;  // B, immediate or read data
  } alu_in_t;

  typedef struct packed {
    op_e             op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sp;
    logic [XLEN-1:0] pc;   // Already points past the instruction
    logic [XLEN-1:0] imm;  // Sign extended
  } addr_in_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } putc_t;

endpackage
